/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert
LINTFLAGS := --lint-only --timing --assert
TOP       := sub_mult_tb
RTL_TOP   := sub_mult
FILELIST  := files.f
MDIR      := obj_dir
LOG       := sim.log
PASS_MSG  := Result: PASSED

.PHONY: all lint lint_rtl build sim clean

all: sim

lint: lint_rtl
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

lint_rtl:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(MDIR)

sim: build
	./$(MDIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass" && exit 1)

clean:
	rm -rf $(MDIR) $(LOG)

/* files.f */
+incdir+hdl
hdl/sub_mult_pkg.sv
hdl/axis_if.sv
hdl/axis_skid_buffer.sv
hdl/frame_extender.sv
hdl/sub_mult_join.sv
hdl/sub_mult.sv
verification/sub_mult_tb.sv

/* hdl/axis_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface axis_if #(
  parameter type payload_t = logic
);

  payload_t tdata;
  logic     tvalid;
  logic     tready;
  logic     tlast;

  // Producer side
  modport src (
    output tdata,
    output tvalid,
    output tlast,
    input  tready
  );

  // Consumer side
  modport snk (
    input  tdata,
    input  tvalid,
    input  tlast,
    output tready
  );

endinterface

`default_nettype wire

/* hdl/axis_skid_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module axis_skid_buffer #(
  parameter type payload_t = logic
) (
  input  logic clk,
  input  logic reset,
  axis_if.snk  s,
  axis_if.src  m
);

  // Output register
  payload_t m_tdata_reg;
  logic     m_tlast_reg;
  logic     m_tvalid_reg;
  logic     m_tvalid_next;

  // Skid register, catches the beat accepted while the output stalls
  payload_t temp_tdata_reg;
  logic     temp_tlast_reg;
  logic     temp_tvalid_reg;
  logic     temp_tvalid_next;

  logic s_tready_reg;
  logic s_tready_early;
  logic store_in_to_out;
  logic store_in_to_temp;
  logic store_temp_to_out;

  // Ready for next cycle if output drains or skid slot stays free
  assign s_tready_early = m.tready || (!temp_tvalid_reg && (!m_tvalid_reg || !s.tvalid));

  always_comb begin
    m_tvalid_next     = m_tvalid_reg;
    temp_tvalid_next  = temp_tvalid_reg;
    store_in_to_out   = 1'b0;
    store_in_to_temp  = 1'b0;
    store_temp_to_out = 1'b0;

    if (s_tready_reg) begin
      if (m.tready || !m_tvalid_reg) begin
        // Output free, go straight through
        m_tvalid_next   = s.tvalid;
        store_in_to_out = 1'b1;
      end else begin
        temp_tvalid_next = s.tvalid;
        store_in_to_temp = 1'b1;
      end
    end else if (m.tready) begin
      // Drain the skid slot
      m_tvalid_next     = temp_tvalid_reg;
      temp_tvalid_next  = 1'b0;
      store_temp_to_out = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      s_tready_reg    <= 1'b0;
      m_tvalid_reg    <= 1'b0;
      temp_tvalid_reg <= 1'b0;
    end else begin
      s_tready_reg    <= s_tready_early;
      m_tvalid_reg    <= m_tvalid_next;
      temp_tvalid_reg <= temp_tvalid_next;
    end
  end

  // Payload path
  always_ff @(posedge clk) begin
    if (store_in_to_out) begin
      m_tdata_reg <= s.tdata;
      m_tlast_reg <= s.tlast;
    end else if (store_temp_to_out) begin
      m_tdata_reg <= temp_tdata_reg;
      m_tlast_reg <= temp_tlast_reg;
    end

    if (store_in_to_temp) begin
      temp_tdata_reg <= s.tdata;
      temp_tlast_reg <= s.tlast;
    end
  end

  assign s.tready = s_tready_reg;
  assign m.tvalid = m_tvalid_reg;
  assign m.tdata  = m_tdata_reg;
  assign m.tlast  = m_tlast_reg;

  // A stalled beat must not change under the consumer
  a_stall_stable: assert property (@(posedge clk) disable iff (reset)
    m.tvalid && !m.tready |=> m.tvalid && $stable(m.tdata) && $stable(m.tlast))
    else $error("skid output changed while stalled");

endmodule

`default_nettype wire

/* hdl/frame_extender.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_extender #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,

  // External stream
  input  payload_t s_tdata,
  input  logic     s_tvalid,
  output logic     s_tready,
  input  logic     s_tlast,

  // Joint frame end from the join stage
  input  logic     frame_done,

  axis_if.src      lane
);

  logic hold;

  axis_if #(.payload_t(payload_t)) skid_in ();

  // Final beat of this lane waits here until the longest frame is done
  assign hold = lane.tvalid && lane.tlast && !frame_done;

  // In hold the registered beat loops back into the skid input.
  // The copy is offered only while the held beat is being taken, so the
  // skid slot never ends up with a stale copy when the hold is released
  assign skid_in.tdata  = hold ? lane.tdata : s_tdata;
  assign skid_in.tlast  = hold ? lane.tlast : s_tlast;
  assign skid_in.tvalid = hold ? lane.tready : s_tvalid;

  // Next frame is stalled at the port during hold
  assign s_tready = hold ? 1'b0 : skid_in.tready;

  axis_skid_buffer #(
    .payload_t(payload_t)
  ) skid (
    .clk   (clk),
    .reset (reset),
    .s     (skid_in),
    .m     (lane)
  );

  // Held beat is still presented on the next cycle unless the frame closed
  a_hold_repeats: assert property (@(posedge clk) disable iff (reset)
    lane.tvalid && lane.tlast && !frame_done |=> lane.tvalid && lane.tlast)
    else $error("held final beat vanished before frame end");

endmodule

`default_nettype wire

/* hdl/sub_mult.sv */
`timescale 1ns/1ps
`default_nettype none

module sub_mult (
  input  logic                  clk,
  input  logic                  reset,

  // Sample stream
  input  sub_mult_pkg::sample_t s_data_tdata,
  input  logic                  s_data_tvalid,
  output logic                  s_data_tready,
  input  logic                  s_data_tlast,

  // Grid stream
  input  sub_mult_pkg::sample_t s_grid_tdata,
  input  logic                  s_grid_tvalid,
  output logic                  s_grid_tready,
  input  logic                  s_grid_tlast,

  // Scale stream
  input  sub_mult_pkg::scale_t  s_scale_tdata,
  input  logic                  s_scale_tvalid,
  output logic                  s_scale_tready,
  input  logic                  s_scale_tlast,

  // Result stream
  output sub_mult_pkg::result_t m_data_tdata,
  output logic                  m_data_tvalid,
  input  logic                  m_data_tready,
  output logic                  m_data_tlast
);

  import sub_mult_pkg::*;

  logic frame_done;

  axis_if #(.payload_t(sample_t)) data_lane ();
  axis_if #(.payload_t(sample_t)) grid_lane ();
  axis_if #(.payload_t(scale_t))  scale_lane ();
  axis_if #(.payload_t(result_t)) join_out ();
  axis_if #(.payload_t(result_t)) out_stage ();

  // Input lanes, each stretches a short frame
  frame_extender #(
    .payload_t(sample_t)
  ) u_data_ext (
    .clk        (clk),
    .reset      (reset),
    .s_tdata    (s_data_tdata),
    .s_tvalid   (s_data_tvalid),
    .s_tready   (s_data_tready),
    .s_tlast    (s_data_tlast),
    .frame_done (frame_done),
    .lane       (data_lane)
  );

  frame_extender #(
    .payload_t(sample_t)
  ) u_grid_ext (
    .clk        (clk),
    .reset      (reset),
    .s_tdata    (s_grid_tdata),
    .s_tvalid   (s_grid_tvalid),
    .s_tready   (s_grid_tready),
    .s_tlast    (s_grid_tlast),
    .frame_done (frame_done),
    .lane       (grid_lane)
  );

  frame_extender #(
    .payload_t(scale_t)
  ) u_scale_ext (
    .clk        (clk),
    .reset      (reset),
    .s_tdata    (s_scale_tdata),
    .s_tvalid   (s_scale_tvalid),
    .s_tready   (s_scale_tready),
    .s_tlast    (s_scale_tlast),
    .frame_done (frame_done),
    .lane       (scale_lane)
  );

  // Arithmetic and lane alignment
  sub_mult_join u_join (
    .data_lane  (data_lane),
    .grid_lane  (grid_lane),
    .scale_lane (scale_lane),
    .join_out   (join_out),
    .frame_done (frame_done)
  );

  // Output stage takes the back-pressure
  axis_skid_buffer #(
    .payload_t(result_t)
  ) u_out_skid (
    .clk   (clk),
    .reset (reset),
    .s     (join_out),
    .m     (out_stage)
  );

  assign m_data_tdata     = out_stage.tdata;
  assign m_data_tvalid    = out_stage.tvalid;
  assign m_data_tlast     = out_stage.tlast;
  assign out_stage.tready = m_data_tready;

endmodule

`default_nettype wire

/* hdl/sub_mult_join.sv */
`timescale 1ns/1ps
`default_nettype none

module sub_mult_join (
  axis_if.snk  data_lane,
  axis_if.snk  grid_lane,
  axis_if.snk  scale_lane,
  axis_if.src  join_out,
  output logic frame_done
);

  import sub_mult_pkg::*;

  localparam int DATA_W  = $bits(sample_t);
  localparam int SCALE_W = $bits(scale_t);
  localparam int RSLT_W  = $bits(result_t);

  sample_t                  sample_word;
  sample_t                  grid_word;
  sample_t                  diff;
  scale_t                   scale_word;
  logic signed [PROD_W-1:0] diff_ext;
  logic signed [PROD_W-1:0] scale_ext;
  logic signed [PROD_W-1:0] product;
  logic                     all_valid;

  assign sample_word = data_lane.tdata;
  assign grid_word   = grid_lane.tdata;
  assign scale_word  = scale_lane.tdata;

  // Difference wraps at the sample width
  assign diff = sample_word - grid_word;

  assign diff_ext  = {{(PROD_W-DATA_W){diff[DATA_W-1]}}, diff};
  assign scale_ext = {{(PROD_W-SCALE_W){scale_word[SCALE_W-1]}}, scale_word};
  assign product   = diff_ext * scale_ext;

  // Rescale to the result format, upper bits dropped
  assign join_out.tdata = product[RSLT_LSB +: RSLT_W];

  assign all_valid = data_lane.tvalid && grid_lane.tvalid && scale_lane.tvalid;

  assign join_out.tvalid = all_valid;
  assign join_out.tlast  = data_lane.tlast && grid_lane.tlast && scale_lane.tlast;

  // A lane is taken only together with the other two
  assign data_lane.tready  = join_out.tready && grid_lane.tvalid && scale_lane.tvalid;
  assign grid_lane.tready  = join_out.tready && data_lane.tvalid && scale_lane.tvalid;
  assign scale_lane.tready = join_out.tready && data_lane.tvalid && grid_lane.tvalid;

  assign frame_done = all_valid && join_out.tready && join_out.tlast;

endmodule

`default_nettype wire

/* hdl/sub_mult_macros.svh */
`ifndef SUB_MULT_MACROS_SVH
`define SUB_MULT_MACROS_SVH

// Sample and grid word, Q3.12
`define SUB_MULT_DATA_W     16
`define SUB_MULT_DATA_FRAC  12

// Scale word, Q3.12
`define SUB_MULT_SCALE_W    16
`define SUB_MULT_SCALE_FRAC 12

// Result word, Q3.12
`define SUB_MULT_RSLT_W     16
`define SUB_MULT_RSLT_FRAC  12

`endif

/* hdl/sub_mult_pkg.sv */
`default_nettype none

`include "sub_mult_macros.svh"

package sub_mult_pkg;

  // Sample and grid share one format
  typedef logic signed [`SUB_MULT_DATA_W-1:0]  sample_t;

  typedef logic signed [`SUB_MULT_SCALE_W-1:0] scale_t;

  typedef logic signed [`SUB_MULT_RSLT_W-1:0]  result_t;

  // Full product of difference and scale
  localparam int PROD_W = `SUB_MULT_DATA_W + `SUB_MULT_SCALE_W;

  // Product bit that lines up with the result LSB
  localparam int RSLT_LSB = `SUB_MULT_DATA_FRAC + `SUB_MULT_SCALE_FRAC
                          - `SUB_MULT_RSLT_FRAC;

endpackage

`default_nettype wire

/* verification/sub_mult_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module sub_mult_tb;

  import sub_mult_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int MAX_LEN    = 8;
  // Q3.12 operands into a Q3.12 result
  localparam int SHIFT      = 12;

  localparam int FRAMES_EQUAL   = 6;
  localparam int FRAMES_UNEQUAL = 10;
  localparam int FRAMES_STALL   = 10;
  localparam int FRAMES_EXTREME = 10;
  localparam int FRAMES_LONG    = 40;
  localparam int TOTAL_FRAMES   = FRAMES_EQUAL + FRAMES_UNEQUAL + FRAMES_STALL
                                + FRAMES_EXTREME + FRAMES_LONG;

  logic    clk;
  logic    reset;
  sample_t s_data_tdata;
  logic    s_data_tvalid;
  logic    s_data_tready;
  logic    s_data_tlast;
  sample_t s_grid_tdata;
  logic    s_grid_tvalid;
  logic    s_grid_tready;
  logic    s_grid_tlast;
  scale_t  s_scale_tdata;
  logic    s_scale_tvalid;
  logic    s_scale_tready;
  logic    s_scale_tlast;
  result_t m_data_tdata;
  logic    m_data_tvalid;
  logic    m_data_tready;
  logic    m_data_tlast;

  int error_count;
  int tests_run;
  int tests_failed;

  // Beats per stream, flattened over all frames of a test
  logic [15:0] data_q[$];
  bit          data_last_q[$];
  logic [15:0] grid_q[$];
  bit          grid_last_q[$];
  logic [15:0] scale_q[$];
  bit          scale_last_q[$];
  logic [15:0] exp_data_q[$];
  bit          exp_last_q[$];

  sub_mult UUT (
    .clk            (clk),
    .reset          (reset),
    .s_data_tdata   (s_data_tdata),
    .s_data_tvalid  (s_data_tvalid),
    .s_data_tready  (s_data_tready),
    .s_data_tlast   (s_data_tlast),
    .s_grid_tdata   (s_grid_tdata),
    .s_grid_tvalid  (s_grid_tvalid),
    .s_grid_tready  (s_grid_tready),
    .s_grid_tlast   (s_grid_tlast),
    .s_scale_tdata  (s_scale_tdata),
    .s_scale_tvalid (s_scale_tvalid),
    .s_scale_tready (s_scale_tready),
    .s_scale_tlast  (s_scale_tlast),
    .m_data_tdata   (m_data_tdata),
    .m_data_tvalid  (m_data_tvalid),
    .m_data_tready  (m_data_tready),
    .m_data_tlast   (m_data_tlast)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Budget of 20 cycles per beat of the longest possible frame
  initial begin
    #(TOTAL_FRAMES * MAX_LEN * 20 * CLK_PERIOD);
    $display("Timeout: the DUT stopped producing results at %0t", $time);
    $display("Result: FAILED");
    $finish;
  end

  // (sample - grid) wraps at 16 bits, full product, then drop SHIFT fraction bits
  function automatic logic [15:0] expected_result(input logic [15:0] sample,
                                                  input logic [15:0] grid,
                                                  input logic [15:0] scale);
    logic signed [15:0] diff;
    logic signed [31:0] prod;
    diff = sample - grid;
    prod = 32'(diff) * 32'($signed(scale));
    return prod[SHIFT +: 16];
  endfunction

  function automatic logic [15:0] pick_value(input bit extreme);
    if (!extreme) begin
      return 16'($urandom());
    end
    case ($urandom_range(0, 5))
      0:       return 16'h7fff;
      1:       return 16'h8000;
      2:       return 16'h8001;
      3:       return 16'hffff;
      4:       return 16'h0001;
      default: return 16'h0000;
    endcase
  endfunction

  task automatic build_frames(input int n_frames, input bit equal_len, input bit extreme);
    int          f;
    int          i;
    int          len_d;
    int          len_g;
    int          len_s;
    int          len_max;
    logic [15:0] d [MAX_LEN];
    logic [15:0] g [MAX_LEN];
    logic [15:0] s [MAX_LEN];
    data_q.delete();
    data_last_q.delete();
    grid_q.delete();
    grid_last_q.delete();
    scale_q.delete();
    scale_last_q.delete();
    exp_data_q.delete();
    exp_last_q.delete();
    for (f = 0; f < n_frames; f++) begin
      len_d = $urandom_range(1, MAX_LEN);
      len_g = equal_len ? len_d : $urandom_range(1, MAX_LEN);
      len_s = equal_len ? len_d : $urandom_range(1, MAX_LEN);
      len_max = (len_d > len_g) ? len_d : len_g;
      len_max = (len_s > len_max) ? len_s : len_max;
      for (i = 0; i < MAX_LEN; i++) begin
        d[i] = pick_value(extreme);
        g[i] = pick_value(extreme);
        s[i] = pick_value(extreme);
      end
      for (i = 0; i < len_d; i++) begin
        data_q.push_back(d[i]);
        data_last_q.push_back(i == len_d - 1);
      end
      for (i = 0; i < len_g; i++) begin
        grid_q.push_back(g[i]);
        grid_last_q.push_back(i == len_g - 1);
      end
      for (i = 0; i < len_s; i++) begin
        scale_q.push_back(s[i]);
        scale_last_q.push_back(i == len_s - 1);
      end
      // Short frames repeat their final beat up to the longest one
      for (i = 0; i < len_max; i++) begin
        exp_data_q.push_back(expected_result(d[(i < len_d) ? i : len_d - 1],
                                             g[(i < len_g) ? i : len_g - 1],
                                             s[(i < len_s) ? i : len_s - 1]));
        exp_last_q.push_back(i == len_max - 1);
      end
    end
  endtask

  task automatic present_beat(input int sel, input logic valid, input logic [15:0] word,
                              input logic last);
    case (sel)
      0: begin
        s_data_tvalid = valid;
        s_data_tdata  = word;
        s_data_tlast  = last;
      end
      1: begin
        s_grid_tvalid = valid;
        s_grid_tdata  = word;
        s_grid_tlast  = last;
      end
      default: begin
        s_scale_tvalid = valid;
        s_scale_tdata  = word;
        s_scale_tlast  = last;
      end
    endcase
  endtask

  function automatic logic stream_ready(input int sel);
    case (sel)
      0:       return s_data_tready;
      1:       return s_grid_tready;
      default: return s_scale_tready;
    endcase
  endfunction

  task automatic get_beat(input int sel, input int idx, output logic [15:0] word,
                          output bit last);
    case (sel)
      0: begin
        word = data_q[idx];
        last = data_last_q[idx];
      end
      1: begin
        word = grid_q[idx];
        last = grid_last_q[idx];
      end
      default: begin
        word = scale_q[idx];
        last = scale_last_q[idx];
      end
    endcase
  endtask

  task automatic drive_stream(input int sel, input int gap_pct);
    int          idx;
    int          total;
    int          gap;
    logic [15:0] word;
    bit          last;
    total = (sel == 0) ? data_q.size() : (sel == 1) ? grid_q.size() : scale_q.size();
    for (idx = 0; idx < total; idx++) begin
      get_beat(sel, idx, word, last);
      gap = ($urandom_range(0, 99) < gap_pct) ? $urandom_range(1, 3) : 0;
      repeat (gap) begin
        @(negedge clk);
        present_beat(sel, 1'b0, word, last);
      end
      @(negedge clk);
      present_beat(sel, 1'b1, word, last);
      // tready only changes on the rising edge, so it is settled here
      #1;
      while (!stream_ready(sel)) begin
        @(negedge clk);
        #1;
      end
    end
    @(negedge clk);
    present_beat(sel, 1'b0, 16'h0000, 1'b0);
  endtask

  task automatic collect_results(input int ready_pct, output int got);
    logic [15:0] prev_data;
    logic        prev_last;
    bit          stalled;
    got = 0;
    stalled = 1'b0;
    while (got < exp_data_q.size()) begin
      @(negedge clk);
      m_data_tready = ($urandom_range(0, 99) < ready_pct);
      #1;
      if (stalled && (m_data_tvalid !== 1'b1 || m_data_tdata !== prev_data
                      || m_data_tlast !== prev_last)) begin
        error_count++;
        $display("ERR %0t: output changed while stalled, beat %0d", $time, got);
      end
      if (m_data_tvalid && m_data_tready) begin
        if (m_data_tdata !== exp_data_q[got] || m_data_tlast !== exp_last_q[got]) begin
          error_count++;
          $display("ERR %0t: beat %0d got %h last %b, expected %h last %b", $time, got,
                   m_data_tdata, m_data_tlast, exp_data_q[got], exp_last_q[got]);
        end
        got++;
        stalled = 1'b0;
      end else begin
        stalled   = m_data_tvalid;
        prev_data = m_data_tdata;
        prev_last = m_data_tlast;
      end
    end
  endtask

  // Nothing may follow the last expected beat
  task automatic check_idle();
    repeat (12) begin
      @(negedge clk);
      m_data_tready = 1'b1;
      #1;
      if (m_data_tvalid) begin
        error_count++;
        $display("ERR %0t: extra output beat %h", $time, m_data_tdata);
      end
    end
  endtask

  task automatic report_test(input int id, input string name, input int errors_before,
                             input int beats);
    tests_run++;
    if (error_count == errors_before) begin
      $display("Test %0d %s: ok, %0d beats checked", id, name, beats);
    end else begin
      tests_failed++;
      $display("Test %0d %s: failed with %0d errors", id, name, error_count - errors_before);
    end
  endtask

  task automatic check_reset_state();
    int errors_before;
    errors_before = error_count;
    @(negedge clk);
    #1;
    if (m_data_tvalid !== 1'b0) begin
      error_count++;
      $display("ERR %0t: m_data_tvalid is %b after reset", $time, m_data_tvalid);
    end
    if (s_data_tready !== 1'b1 || s_grid_tready !== 1'b1 || s_scale_tready !== 1'b1) begin
      error_count++;
      $display("ERR %0t: input tready %b%b%b after reset, expected 111", $time,
               s_data_tready, s_grid_tready, s_scale_tready);
    end
    report_test(1, "reset state", errors_before, 0);
  endtask

  task automatic run_test(input int id, input string name, input int n_frames,
                          input bit equal_len, input bit extreme,
                          input int gap_pct, input int ready_pct);
    int errors_before;
    int beats;
    errors_before = error_count;
    build_frames(n_frames, equal_len, extreme);
    fork
      drive_stream(0, gap_pct);
      drive_stream(1, gap_pct);
      drive_stream(2, gap_pct);
      collect_results(ready_pct, beats);
    join
    check_idle();
    report_test(id, name, errors_before, beats);
  endtask

  initial begin
    void'($urandom(32'hf8bd));
    error_count    = 0;
    tests_run      = 0;
    tests_failed   = 0;
    reset          = 1'b1;
    s_data_tdata   = '0;
    s_data_tvalid  = 1'b0;
    s_data_tlast   = 1'b0;
    s_grid_tdata   = '0;
    s_grid_tvalid  = 1'b0;
    s_grid_tlast   = 1'b0;
    s_scale_tdata  = '0;
    s_scale_tvalid = 1'b0;
    s_scale_tlast  = 1'b0;
    m_data_tready  = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    check_reset_state();
    run_test(2, "equal frames", FRAMES_EQUAL, 1'b1, 1'b0, 0, 100);
    run_test(3, "unequal frames", FRAMES_UNEQUAL, 1'b0, 1'b0, 10, 100);
    run_test(4, "back-pressure", FRAMES_STALL, 1'b0, 1'b0, 20, 50);
    run_test(5, "extreme operands", FRAMES_EXTREME, 1'b0, 1'b1, 10, 70);
    run_test(6, "long run", FRAMES_LONG, 1'b0, 1'b0, 30, 60);

    $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
             error_count);
    if (error_count == 0 && tests_failed == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
